//--- dram_pkg.sv
package dram_pkg;

    localparam int id_w  = 8;
    localparam int row_w = 11;
    localparam int col_w = 10;
    localparam int len_w = 4;

    // Command gaps in clock cycles
    localparam int t_rp  = 3;
    localparam int t_rcd = 3;

    localparam logic [1:0] resp_okay = 2'b00;

    typedef enum logic [2:0] {
        seq_idle,
        seq_pre,
        seq_pre_wait,
        seq_act,
        seq_act_wait,
        seq_col_wr,
        seq_col_rd,
        seq_rd_wait
    } seq_state_e;

    typedef enum logic [2:0] {
        op_nop,
        op_pre,
        op_act,
        op_wr,
        op_rd
    } dram_op_e;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [31:0]     addr;
    } aw_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } w_beat_t;

    typedef struct packed {
        logic [id_w-1:0]  id;
        logic [31:0]      addr;
        logic [len_w-1:0] len;
    } ar_req_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [31:0]     data;
        logic            last;
    } r_beat_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } b_resp_t;

    typedef struct packed {
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
        logic [31:0]      data;
        logic [3:0]       strb;
    } wr_cmd_t;

    typedef struct packed {
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
    } rd_cmd_t;

    // Active-low controls, wen is per byte
    typedef struct packed {
        logic             csn;
        logic             rasn;
        logic             casn;
        logic [3:0]       wen;
        logic [row_w-1:0] a;
        logic [31:0]      d;
    } dram_pins_t;

endpackage

//--- dram_write_port.sv
`timescale 1ns/100ps

module dram_write_port
    import dram_pkg::*;
(
    input  logic      dram_clk,
    input  logic      dram_rst,
    input  logic      aw_valid,
    input  logic      w_valid,
    input  logic      b_ready,
    input  aw_req_t   aw,
    input  w_beat_t   w,
    output logic      aw_ready,
    output logic      b_valid,
    output b_resp_t   b,
    output logic      wr_pending,
    output wr_cmd_t   wr_cmd,
    input  logic      wr_done
);

    logic [id_w-1:0] id_q;
    logic            accept;

    // AW and W are taken together, only into an empty port
    assign aw_ready = aw_valid && w_valid && !wr_pending && !b_valid;
    assign accept   = aw_ready;

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            wr_pending <= 1'b0;
            b_valid    <= 1'b0;
        end else begin
            if (accept) begin
                wr_pending <= 1'b1;
            end else if (wr_done) begin
                wr_pending <= 1'b0;
                b_valid    <= 1'b1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge dram_clk) begin
        if (accept) begin
            id_q        <= aw.id;
            wr_cmd.row  <= aw.addr[22:12];
            wr_cmd.col  <= aw.addr[11:2];
            wr_cmd.data <= w.data;
            wr_cmd.strb <= w.strb;
        end
    end

    assign b.id   = id_q;
    assign b.resp = resp_okay;

endmodule

//--- dram_read_port.sv
`timescale 1ns/100ps

module dram_read_port
    import dram_pkg::*;
(
    input  logic        dram_clk,
    input  logic        dram_rst,
    input  logic        ar_valid,
    input  logic        r_ready,
    input  ar_req_t     ar,
    output logic        ar_ready,
    output logic        r_valid,
    output r_beat_t     r,
    output logic        rd_pending,
    output rd_cmd_t     rd_cmd,
    output logic        rd_beat_done,
    input  logic [31:0] dram_q,
    input  logic        dram_valid
);

    logic [id_w-1:0]  id_q;
    logic [31:0]      addr_q;
    logic [len_w-1:0] len_q;
    logic [len_w-1:0] beat_cnt;
    logic [31:0]      data_q;
    logic             last_beat;

    assign ar_ready     = !rd_pending;
    assign rd_beat_done = r_valid && r_ready;
    assign last_beat    = (beat_cnt == len_q);

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            rd_pending <= 1'b0;
            r_valid    <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            if (ar_valid && ar_ready) begin
                rd_pending <= 1'b1;
                beat_cnt   <= '0;
            end else if (rd_beat_done) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    rd_pending <= 1'b0;
                end
            end
            // One column read in flight at a time
            if (dram_valid) begin
                r_valid <= 1'b1;
            end else if (rd_beat_done) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge dram_clk) begin
        if (ar_valid && ar_ready) begin
            id_q   <= ar.id;
            len_q  <= ar.len;
            addr_q <= ar.addr;
        end else if (rd_beat_done) begin
            addr_q <= addr_q + 32'd4;
        end
        if (dram_valid) begin
            data_q <= dram_q;
        end
    end

    assign rd_cmd.row = addr_q[22:12];
    assign rd_cmd.col = addr_q[11:2];

    assign r.id   = id_q;
    assign r.data = data_q;
    assign r.last = last_beat;

endmodule

//--- dram_cmd_seq.sv
`timescale 1ns/100ps

module dram_cmd_seq
    import dram_pkg::*;
(
    input  logic       dram_clk,
    input  logic       dram_rst,
    input  logic       wr_pending,
    input  wr_cmd_t    wr_cmd,
    output logic       wr_done,
    input  logic       rd_pending,
    input  rd_cmd_t    rd_cmd,
    output logic       rd_issue,
    input  logic       rd_beat_done,
    output dram_pins_t pins
);

    seq_state_e       state;
    seq_state_e       state_nxt;
    dram_op_e         op;
    logic             sel_wr;
    logic             cur_wr;
    logic [row_w-1:0] cur_row;
    logic [col_w-1:0] cur_col;
    logic [row_w-1:0] open_row;
    logic             row_open;
    logic             row_hit;
    logic [2:0]       gap_cnt;

    // In idle the choice is live, later it is the latched one
    assign cur_wr  = (state == seq_idle) ? wr_pending : sel_wr;
    assign cur_row = cur_wr ? wr_cmd.row : rd_cmd.row;
    assign cur_col = cur_wr ? wr_cmd.col : rd_cmd.col;
    assign row_hit = row_open && (open_row == cur_row);

    assign wr_done  = (state == seq_col_wr);
    assign rd_issue = (state == seq_col_rd);

    always_comb begin
        state_nxt = state;
        case (state)
            seq_idle: begin
                if (wr_pending || rd_pending) begin
                    if (row_hit) begin
                        state_nxt = wr_pending ? seq_col_wr : seq_col_rd;
                    end else if (row_open) begin
                        state_nxt = seq_pre;
                    end else begin
                        state_nxt = seq_act;
                    end
                end
            end
            seq_pre:      state_nxt = seq_pre_wait;
            seq_pre_wait: begin
                if (gap_cnt == '0) begin
                    state_nxt = seq_act;
                end
            end
            seq_act:      state_nxt = seq_act_wait;
            seq_act_wait: begin
                if (gap_cnt == '0) begin
                    state_nxt = sel_wr ? seq_col_wr : seq_col_rd;
                end
            end
            seq_col_wr:   state_nxt = seq_idle;
            seq_col_rd:   state_nxt = seq_rd_wait;
            seq_rd_wait: begin
                // Next beat goes back through the hit check
                if (rd_beat_done) begin
                    state_nxt = seq_idle;
                end
            end
            default:      state_nxt = seq_idle;
        endcase
    end

    always_comb begin
        case (state)
            seq_pre:    op = op_pre;
            seq_act:    op = op_act;
            seq_col_wr: op = op_wr;
            seq_col_rd: op = op_rd;
            default:    op = op_nop;
        endcase
    end

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            state    <= seq_idle;
            sel_wr   <= 1'b0;
            row_open <= 1'b0;
            gap_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (state == seq_idle && (wr_pending || rd_pending)) begin
                sel_wr <= wr_pending;
            end
            case (state)
                seq_pre: begin
                    row_open <= 1'b0;
                    gap_cnt  <= 3'(t_rp - 1);
                end
                seq_act: begin
                    row_open <= 1'b1;
                    gap_cnt  <= 3'(t_rcd - 1);
                end
                seq_pre_wait, seq_act_wait: begin
                    if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge dram_clk) begin
        if (state == seq_act) begin
            open_row <= cur_row;
        end
    end

    always_ff @(posedge dram_clk) begin
        if (dram_rst) begin
            pins <= '{csn: 1'b1, rasn: 1'b1, casn: 1'b1, wen: 4'hf, a: '0, d: '0};
        end else begin
            pins <= '{csn: 1'b1, rasn: 1'b1, casn: 1'b1, wen: 4'hf, a: '0, d: '0};
            case (op)
                op_pre: begin
                    pins.csn  <= 1'b0;
                    pins.rasn <= 1'b0;
                    pins.wen  <= 4'h0;
                end
                op_act: begin
                    pins.csn  <= 1'b0;
                    pins.rasn <= 1'b0;
                    pins.a    <= cur_row;
                end
                op_wr: begin
                    pins.csn  <= 1'b0;
                    pins.casn <= 1'b0;
                    pins.wen  <= ~wr_cmd.strb;
                    pins.a    <= row_w'(cur_col);
                    pins.d    <= wr_cmd.data;
                end
                op_rd: begin
                    pins.csn  <= 1'b0;
                    pins.casn <= 1'b0;
                    pins.a    <= row_w'(cur_col);
                end
                default: ;
            endcase
        end
    end

endmodule

//--- dram_ctrl_top.sv
`timescale 1ns/100ps

module dram_ctrl_top
    import dram_pkg::*;
(
    input  logic        dram_clk,
    input  logic        dram_rst,
    input  logic        aw_valid,
    input  aw_req_t     aw,
    input  logic        w_valid,
    input  w_beat_t     w,
    output logic        aw_ready,
    output logic        b_valid,
    output b_resp_t     b,
    input  logic        b_ready,
    input  logic        ar_valid,
    input  ar_req_t     ar,
    output logic        ar_ready,
    output logic        r_valid,
    output r_beat_t     r,
    input  logic        r_ready,
    output dram_pins_t  dram_pins,
    input  logic [31:0] dram_q,
    input  logic        dram_valid
);

    logic    wr_pending;
    logic    wr_done;
    wr_cmd_t wr_cmd;
    logic    rd_pending;
    logic    rd_beat_done;
    rd_cmd_t rd_cmd;

    dram_write_port u_write_port (
        .dram_clk   (dram_clk),
        .dram_rst   (dram_rst),
        .aw_valid   (aw_valid),
        .w_valid    (w_valid),
        .b_ready    (b_ready),
        .aw         (aw),
        .w          (w),
        .aw_ready   (aw_ready),
        .b_valid    (b_valid),
        .b          (b),
        .wr_pending (wr_pending),
        .wr_cmd     (wr_cmd),
        .wr_done    (wr_done)
    );

    dram_read_port u_read_port (
        .dram_clk     (dram_clk),
        .dram_rst     (dram_rst),
        .ar_valid     (ar_valid),
        .r_ready      (r_ready),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .rd_pending   (rd_pending),
        .rd_cmd       (rd_cmd),
        .rd_beat_done (rd_beat_done),
        .dram_q       (dram_q),
        .dram_valid   (dram_valid)
    );

    dram_cmd_seq u_cmd_seq (
        .dram_clk     (dram_clk),
        .dram_rst     (dram_rst),
        .wr_pending   (wr_pending),
        .wr_cmd       (wr_cmd),
        .wr_done      (wr_done),
        .rd_pending   (rd_pending),
        .rd_cmd       (rd_cmd),
        .rd_issue     (),
        .rd_beat_done (rd_beat_done),
        .pins         (dram_pins)
    );

endmodule

//--- dram_ctrl_asserts.sv
`timescale 1ns/100ps

module dram_ctrl_asserts
    import dram_pkg::*;
(
    input logic       dram_clk,
    input logic       dram_rst,
    input seq_state_e state,
    input dram_op_e   op,
    input logic       row_open,
    input dram_pins_t pins
);

    a_rp_gap: assert property (@(posedge dram_clk) disable iff (dram_rst)
        (op == op_pre) |-> ##(t_rp + 1) (op == op_act))
        else $error("activate does not follow precharge after t_rp");

    a_rcd_gap: assert property (@(posedge dram_clk) disable iff (dram_rst)
        (op == op_act) |-> ##(t_rcd + 1) (op == op_wr || op == op_rd))
        else $error("column command does not follow activate after t_rcd");

    a_col_open: assert property (@(posedge dram_clk) disable iff (dram_rst)
        (op == op_wr || op == op_rd) |-> row_open)
        else $error("column command with no open row");

    // Pins lag the op by one register stage
    a_idle_csn: assert property (@(posedge dram_clk) disable iff (dram_rst)
        (state == seq_idle && op == op_nop) |=> pins.csn)
        else $error("chip select low after an idle cycle");

endmodule

bind dram_cmd_seq dram_ctrl_asserts u_asserts (
    .dram_clk (dram_clk),
    .dram_rst (dram_rst),
    .state    (state),
    .op       (op),
    .row_open (row_open),
    .pins     (pins)
);

//--- tb_dram_model.sv
`timescale 1ns/100ps

module tb_dram_model
    import dram_pkg::*;
#(
    parameter int cas_lat = 1
) (
    input  logic        dram_clk,
    input  logic        dram_rst,
    input  dram_pins_t  pins,
    output logic [31:0] dram_q,
    output logic        dram_valid
);

    logic [31:0]      mem [logic [20:0]];
    logic [row_w-1:0] open_row;
    logic [20:0]      waddr;
    logic             vld_pipe [cas_lat];
    logic [31:0]      q_pipe [cas_lat];

    assign waddr      = {open_row, pins.a[col_w-1:0]};
    assign dram_valid = vld_pipe[cas_lat-1];
    assign dram_q     = q_pipe[cas_lat-1];

    // Unwritten words read back as a pattern of their own address
    function automatic logic [31:0] stored_word(input logic [20:0] wa);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return {wa[10:0], wa} ^ 32'h3c5a_9e17;
    endfunction

    always @(posedge dram_clk) begin
        logic [31:0] merged;
        merged = stored_word(waddr);
        if (dram_rst) begin
            for (int i = 0; i < cas_lat; i++) begin
                vld_pipe[i] <= 1'b0;
            end
        end else begin
            for (int i = cas_lat - 1; i > 0; i--) begin
                vld_pipe[i] <= vld_pipe[i-1];
                q_pipe[i]   <= q_pipe[i-1];
            end
            vld_pipe[0] <= !pins.csn && pins.rasn && !pins.casn && pins.wen == 4'hf;
            q_pipe[0]   <= merged;
            if (!pins.csn && !pins.rasn && pins.casn && pins.wen == 4'hf) begin
                open_row <= pins.a;
            end
            // Column write, one wen bit per byte
            if (!pins.csn && pins.rasn && !pins.casn && pins.wen != 4'hf) begin
                for (int i = 0; i < 4; i++) begin
                    if (!pins.wen[i]) begin
                        merged[8*i +: 8] = pins.d[8*i +: 8];
                    end
                end
                mem[waddr] = merged;
            end
        end
    end

endmodule

//--- tb_dram_ctrl.sv
`timescale 1ns/100ps

module tb_dram_ctrl
    import dram_pkg::*;
();

    localparam int cas_lat    = 3;
    localparam int beat_cost  = t_rp + t_rcd + cas_lat + 8;
    // Beats of tests 2 to 6
    localparam int n_beats    = 16 + 16 + 96 + 64 + 36;
    localparam int max_cycles = n_beats * beat_cost + 2000;

    logic        dram_clk = 1'b0;
    logic        dram_rst;
    logic        aw_valid;
    logic        w_valid;
    logic        b_ready;
    logic        ar_valid;
    logic        r_ready;
    aw_req_t     aw;
    w_beat_t     w;
    ar_req_t     ar;
    logic        aw_ready;
    logic        b_valid;
    b_resp_t     b;
    logic        ar_ready;
    logic        r_valid;
    r_beat_t     r;
    dram_pins_t  dram_pins;
    logic [31:0] dram_q;
    logic        dram_valid;

    logic [31:0] rng = 32'd94085;
    int          cycles = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] ref_mem [logic [20:0]];
    logic [31:0] addrs [8];

    dram_ctrl_top DUT (
        .dram_clk, .dram_rst, .aw_valid, .aw, .w_valid, .w, .aw_ready, .b_valid, .b,
        .b_ready, .ar_valid, .ar, .ar_ready, .r_valid, .r, .r_ready, .dram_pins,
        .dram_q, .dram_valid
    );

    tb_dram_model #(.cas_lat(cas_lat)) u_dram (
        .dram_clk, .dram_rst, .pins(dram_pins), .dram_q, .dram_valid
    );

    always #50 dram_clk = ~dram_clk;

    always @(posedge dram_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [20:0] wa;
        wa = addr[22:2];
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return {wa[10:0], wa} ^ 32'h3c5a_9e17;
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
        logic [31:0] word;
        word = ref_read(addr);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        ref_mem[addr[22:2]] = word;
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [id_w-1:0] awid);
        @(posedge dram_clk);
        aw_valid <= 1'b1;
        w_valid  <= 1'b1;
        aw       <= '{id: awid, addr: addr};
        w        <= '{data: data, strb: strb};
        do @(posedge dram_clk); while (!aw_ready);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        b_ready  <= 1'b1;
        ref_write(addr, data, strb);
        do @(posedge dram_clk); while (!b_valid);
        b_ready <= 1'b0;
        if (b.id != awid) begin
            report_error($sformatf("BID %h, expected %h", b.id, awid));
        end
        if (b.resp != resp_okay) begin
            report_error($sformatf("BRESP %0d on write to %h", b.resp, addr));
        end
    endtask

    // Back-pressure drops RREADY at random cycles
    task automatic read_burst(input logic [31:0] addr, input logic [len_w-1:0] len,
                              input logic [id_w-1:0] arid, input bit bp);
        int          beat;
        logic [31:0] exp;
        @(posedge dram_clk);
        if (r_valid) begin
            report_error("RVALID high with no burst in flight");
        end
        ar_valid <= 1'b1;
        ar       <= '{id: arid, addr: addr, len: len};
        do @(posedge dram_clk); while (!ar_ready);
        ar_valid <= 1'b0;
        r_ready  <= bp ? 1'(next_random()) : 1'b1;
        beat = 0;
        while (beat <= int'(len)) begin
            @(posedge dram_clk);
            if (r_valid && r_ready) begin
                exp = ref_read(addr + 32'(4 * beat));
                if (r.data != exp) begin
                    report_error($sformatf("burst %h beat %0d data %h, expected %h",
                                           addr, beat, r.data, exp));
                end
                if (r.id != arid) begin
                    report_error($sformatf("RID %h, expected %h", r.id, arid));
                end
                if (r.last != (beat == int'(len))) begin
                    report_error($sformatf("burst %h beat %0d RLAST %b", addr, beat, r.last));
                end
                beat++;
            end
            r_ready <= bp ? 1'(next_random()) : 1'b1;
        end
        r_ready <= 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] row;
        logic [31:0] start;
        logic [3:0]  strb;
        int          mark;
        dram_rst = 1'b1;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw       = '0;
        w        = '0;
        ar       = '0;
        repeat (8) @(posedge dram_clk);
        dram_rst <= 1'b0;

        mark = errors;
        repeat (4) begin
            @(posedge dram_clk);
            if (!dram_pins.csn || !dram_pins.rasn || !dram_pins.casn
                    || dram_pins.wen != 4'hf || dram_pins.a != '0 || dram_pins.d != '0) begin
                report_error("DRAM pins not idle after reset");
            end
            if (b_valid || r_valid || aw_ready || !ar_ready) begin
                report_error("AXI handshake outputs wrong after reset");
            end
        end
        end_test("reset values", mark);

        mark = errors;
        row = next_random() & 32'h007f_f000;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = row | (next_random() & 32'h0000_0ffc);
            write_word(addrs[i], next_random(), 4'hf, 8'(next_random()));
        end
        for (int i = 0; i < 8; i++) begin
            read_burst(addrs[i], 4'd0, 8'(next_random()), 1'b0);
        end
        end_test("single writes and read-back", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            strb = 4'(next_random());
            if (strb == 4'h0) begin
                strb = 4'h1;
            end
            write_word(addrs[i], next_random(), strb, 8'(next_random()));
        end
        for (int i = 0; i < 8; i++) begin
            read_burst(addrs[i], 4'd0, 8'(next_random()), 1'b0);
        end
        end_test("partial writes", mark);

        // At least 9 beats, so every burst reaches the next row
        mark = errors;
        for (int i = 0; i < 6; i++) begin
            start = (next_random() & 32'h007f_f000) + 32'h1000 - ((next_random() & 32'h1c) + 4);
            read_burst(start, 4'(next_random()) | 4'h8, 8'(next_random()), 1'b0);
        end
        end_test("bursts across rows", mark);

        mark = errors;
        for (int i = 0; i < 4; i++) begin
            start = (next_random() & 32'h007f_f000) + 32'h1000 - ((next_random() & 32'h1c) + 4);
            read_burst(start, 4'hf, 8'(next_random()), 1'b1);
        end
        end_test("read back-pressure", mark);

        // Reads go to another row than the concurrent writes
        mark = errors;
        row   = next_random() & 32'h007f_f000;
        start = row ^ 32'h0040_0000;
        for (int i = 0; i < 6; i++) begin
            addrs[i] = row | (next_random() & 32'h0000_0ffc);
            fork
                write_word(addrs[i], next_random(), 4'hf, 8'(next_random()));
                read_burst(start | (next_random() & 32'h0000_0ff0), 4'(next_random() & 3),
                           8'(next_random()), 1'b0);
            join
        end
        for (int i = 0; i < 6; i++) begin
            read_burst(addrs[i], 4'd0, 8'(next_random()), 1'b0);
        end
        end_test("responses under load", mark);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- dram_ctrl.f
dram_pkg.sv
dram_write_port.sv
dram_read_port.sv
dram_cmd_seq.sv
dram_ctrl_top.sv
dram_ctrl_asserts.sv
tb_dram_model.sv
tb_dram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_dram_ctrl -f dram_ctrl.f

./obj_dir/Vtb_dram_ctrl | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
